// File: filelist.f
logic/axi_bus_pkg.sv
logic/id_remap_pkg.sv
logic/axi_ax_if.sv
logic/axi_rsp_if.sv
logic/id_remap_table.sv
logic/id_remap_path.sv
logic/axi_iw_converter.sv
tb/tb_axi_iw_converter.sv

// File: logic/axi_ax_if.sv
`timescale 1ns/10ps

// Address channel between two blocks of the converter
// The channel fields are carried as one opaque vector
interface axi_ax_if #(
  parameter int unsigned IdWidth      = 1,
  parameter int unsigned PayloadWidth = 1
);

  logic                    valid;
  logic                    ready;
  // Transaction ID which the remap logic rewrites
  logic [IdWidth-1:0]      id;
  // Address and burst length packed together
  logic [PayloadWidth-1:0] payload;

  // Side that issues the address
  modport sender (
    output valid,
    output id,
    output payload,
    input  ready
  );

  // Side that accepts the address
  modport receiver (
    input  valid,
    input  id,
    input  payload,
    output ready
  );

endinterface

// File: logic/axi_bus_pkg.sv
package axi_bus_pkg;

  // Address width shared by both ports and by the AW and AR channels
  localparam int unsigned AddrWidth = 32;

  // Data width of the W and R channels
  localparam int unsigned DataWidth = 32;

  // AXI4 burst length field carries up to 256 beats
  localparam int unsigned LenWidth = 8;

  // Response code width used by B and R
  localparam int unsigned RespWidth = 2;

  // The manager side issues wide IDs
  localparam int unsigned SlvIdWidth = 4;

  // The subordinate side only accepts narrow IDs
  localparam int unsigned MstIdWidth = 2;

  // Address channel payload is the address followed by the burst length
  localparam int unsigned AxPayloadWidth = AddrWidth + LenWidth;

  // Read data payload keeps the last flag in the lowest bit
  localparam int unsigned RPayloadWidth = DataWidth + RespWidth + 1;

  // Write response payload is only the response code
  localparam int unsigned BPayloadWidth = RespWidth;

  typedef logic [AddrWidth-1:0] addr_t;

  typedef logic [DataWidth-1:0] data_t;

  // One strobe bit per data byte
  typedef logic [DataWidth/8-1:0] strb_t;

  typedef logic [LenWidth-1:0] len_t;

  typedef logic [RespWidth-1:0] resp_t;

  // ID as seen on the slave port of the converter
  typedef logic [SlvIdWidth-1:0] slv_id_t;

  // ID as seen on the master port of the converter
  typedef logic [MstIdWidth-1:0] mst_id_t;

endpackage

// File: logic/axi_iw_converter.sv
`timescale 1ns/10ps

// AXI4 ID width converter from 4 bit manager IDs to 2 bit subordinate IDs
// Write and read directions each own a remap table
module axi_iw_converter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Slave port AW
  input  logic                  slv_aw_valid_i,
  output logic                  slv_aw_ready_o,
  input  axi_bus_pkg::slv_id_t  slv_aw_id_i,
  input  axi_bus_pkg::addr_t    slv_aw_addr_i,
  input  axi_bus_pkg::len_t     slv_aw_len_i,

  // Slave port W
  input  logic                  slv_w_valid_i,
  output logic                  slv_w_ready_o,
  input  axi_bus_pkg::data_t    slv_w_data_i,
  input  axi_bus_pkg::strb_t    slv_w_strb_i,
  input  logic                  slv_w_last_i,

  // Slave port B
  output logic                  slv_b_valid_o,
  input  logic                  slv_b_ready_i,
  output axi_bus_pkg::slv_id_t  slv_b_id_o,
  output axi_bus_pkg::resp_t    slv_b_resp_o,

  // Slave port AR
  input  logic                  slv_ar_valid_i,
  output logic                  slv_ar_ready_o,
  input  axi_bus_pkg::slv_id_t  slv_ar_id_i,
  input  axi_bus_pkg::addr_t    slv_ar_addr_i,
  input  axi_bus_pkg::len_t     slv_ar_len_i,

  // Slave port R
  output logic                  slv_r_valid_o,
  input  logic                  slv_r_ready_i,
  output axi_bus_pkg::slv_id_t  slv_r_id_o,
  output axi_bus_pkg::data_t    slv_r_data_o,
  output axi_bus_pkg::resp_t    slv_r_resp_o,
  output logic                  slv_r_last_o,

  // Master port AW
  output logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  output axi_bus_pkg::mst_id_t  mst_aw_id_o,
  output axi_bus_pkg::addr_t    mst_aw_addr_o,
  output axi_bus_pkg::len_t     mst_aw_len_o,

  // Master port W
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  output axi_bus_pkg::data_t    mst_w_data_o,
  output axi_bus_pkg::strb_t    mst_w_strb_o,
  output logic                  mst_w_last_o,

  // Master port B
  input  logic                  mst_b_valid_i,
  output logic                  mst_b_ready_o,
  input  axi_bus_pkg::mst_id_t  mst_b_id_i,
  input  axi_bus_pkg::resp_t    mst_b_resp_i,

  // Master port AR
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  output axi_bus_pkg::mst_id_t  mst_ar_id_o,
  output axi_bus_pkg::addr_t    mst_ar_addr_o,
  output axi_bus_pkg::len_t     mst_ar_len_o,

  // Master port R
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o,
  input  axi_bus_pkg::mst_id_t  mst_r_id_i,
  input  axi_bus_pkg::data_t    mst_r_data_i,
  input  axi_bus_pkg::resp_t    mst_r_resp_i,
  input  logic                  mst_r_last_i
);

  // Write direction channels
  axi_ax_if #(
    .IdWidth      ( axi_bus_pkg::SlvIdWidth     ),
    .PayloadWidth ( axi_bus_pkg::AxPayloadWidth )
  ) slv_aw ();
  axi_ax_if #(
    .IdWidth      ( axi_bus_pkg::MstIdWidth     ),
    .PayloadWidth ( axi_bus_pkg::AxPayloadWidth )
  ) mst_aw ();
  axi_rsp_if #(
    .IdWidth      ( axi_bus_pkg::MstIdWidth    ),
    .PayloadWidth ( axi_bus_pkg::BPayloadWidth )
  ) mst_b ();
  axi_rsp_if #(
    .IdWidth      ( axi_bus_pkg::SlvIdWidth    ),
    .PayloadWidth ( axi_bus_pkg::BPayloadWidth )
  ) slv_b ();

  // Read direction channels
  axi_ax_if #(
    .IdWidth      ( axi_bus_pkg::SlvIdWidth     ),
    .PayloadWidth ( axi_bus_pkg::AxPayloadWidth )
  ) slv_ar ();
  axi_ax_if #(
    .IdWidth      ( axi_bus_pkg::MstIdWidth     ),
    .PayloadWidth ( axi_bus_pkg::AxPayloadWidth )
  ) mst_ar ();
  axi_rsp_if #(
    .IdWidth      ( axi_bus_pkg::MstIdWidth    ),
    .PayloadWidth ( axi_bus_pkg::RPayloadWidth )
  ) mst_r ();
  axi_rsp_if #(
    .IdWidth      ( axi_bus_pkg::SlvIdWidth    ),
    .PayloadWidth ( axi_bus_pkg::RPayloadWidth )
  ) slv_r ();

  // AW from the manager is packed as address then length
  assign slv_aw.valid   = slv_aw_valid_i;
  assign slv_aw.id      = slv_aw_id_i;
  assign slv_aw.payload = {slv_aw_addr_i, slv_aw_len_i};
  assign slv_aw_ready_o = slv_aw.ready;

  assign mst_aw_valid_o = mst_aw.valid;
  assign mst_aw_id_o    = mst_aw.id;
  assign {mst_aw_addr_o, mst_aw_len_o} = mst_aw.payload;
  assign mst_aw.ready   = mst_aw_ready_i;

  // B carries only the response code
  assign mst_b.valid   = mst_b_valid_i;
  assign mst_b.id      = mst_b_id_i;
  assign mst_b.payload = mst_b_resp_i;
  assign mst_b_ready_o = mst_b.ready;

  assign slv_b_valid_o = slv_b.valid;
  assign slv_b_id_o    = slv_b.id;
  assign slv_b_resp_o  = slv_b.payload;
  assign slv_b.ready   = slv_b_ready_i;

  // AR uses the same packing as AW
  assign slv_ar.valid   = slv_ar_valid_i;
  assign slv_ar.id      = slv_ar_id_i;
  assign slv_ar.payload = {slv_ar_addr_i, slv_ar_len_i};
  assign slv_ar_ready_o = slv_ar.ready;

  assign mst_ar_valid_o = mst_ar.valid;
  assign mst_ar_id_o    = mst_ar.id;
  assign {mst_ar_addr_o, mst_ar_len_o} = mst_ar.payload;
  assign mst_ar.ready   = mst_ar_ready_i;

  // R puts last in bit 0 where the read path looks for it
  assign mst_r.valid   = mst_r_valid_i;
  assign mst_r.id      = mst_r_id_i;
  assign mst_r.payload = {mst_r_data_i, mst_r_resp_i, mst_r_last_i};
  assign mst_r_ready_o = mst_r.ready;

  assign slv_r_valid_o = slv_r.valid;
  assign slv_r_id_o    = slv_r.id;
  assign {slv_r_data_o, slv_r_resp_o, slv_r_last_o} = slv_r.payload;
  assign slv_r.ready   = slv_r_ready_i;

  // W has no ID in AXI4 and goes straight through
  assign mst_w_valid_o = slv_w_valid_i;
  assign mst_w_data_o  = slv_w_data_i;
  assign mst_w_strb_o  = slv_w_strb_i;
  assign mst_w_last_o  = slv_w_last_i;
  assign slv_w_ready_o = mst_w_ready_i;

  // Every B ends a write so no last flag is needed
  id_remap_path #(
    .LastInPayload ( 1'b0 )
  ) i_write_path (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .slv_ax  ( slv_aw  ),
    .mst_ax  ( mst_aw  ),
    .mst_rsp ( mst_b   ),
    .slv_rsp ( slv_b   )
  );

  // Read bursts release their entry on the last beat only
  id_remap_path #(
    .LastInPayload ( 1'b1 )
  ) i_read_path (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .slv_ax  ( slv_ar  ),
    .mst_ax  ( mst_ar  ),
    .mst_rsp ( mst_r   ),
    .slv_rsp ( slv_r   )
  );

endmodule

// File: logic/axi_rsp_if.sv
`timescale 1ns/10ps

// Response channel between two blocks of the converter
// Used for both B and R with a payload width that fits each
interface axi_rsp_if #(
  parameter int unsigned IdWidth      = 1,
  parameter int unsigned PayloadWidth = 1
);

  logic                    valid;
  logic                    ready;
  // ID of the transaction that this response belongs to
  logic [IdWidth-1:0]      id;
  // Response code and for reads the data and the last flag
  logic [PayloadWidth-1:0] payload;

  // Side that produces the response
  modport sender (
    output valid,
    output id,
    output payload,
    input  ready
  );

  // Side that consumes the response
  modport receiver (
    input  valid,
    input  id,
    input  payload,
    output ready
  );

endinterface

// File: logic/id_remap_path.sv
`timescale 1ns/10ps

// One direction of the converter
// Addresses go out with a table index as ID and responses come back with the
// original slave ID restored
module id_remap_path #(
  // Set when bit 0 of the response payload is the last flag of a burst
  parameter bit LastInPayload = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Address from the manager with a wide ID
  axi_ax_if.receiver slv_ax,
  // Address to the subordinate with a narrow ID
  axi_ax_if.sender   mst_ax,
  // Response from the subordinate with a narrow ID
  axi_rsp_if.receiver mst_rsp,
  // Response to the manager with the wide ID restored
  axi_rsp_if.sender   slv_rsp
);

  logic                 grant;
  id_remap_pkg::idx_t   grant_idx;
  axi_bus_pkg::slv_id_t lookup_id;

  // Handshake and release qualifiers
  logic                 ax_xfer;
  logic                 rsp_xfer;
  logic                 rsp_last;
  logic                 rsp_release;

  // Without a grant the request is held back on both sides of the path
  assign mst_ax.valid   = slv_ax.valid & grant;
  assign slv_ax.ready   = mst_ax.ready & grant;
  // The table index doubles as the outgoing ID
  assign mst_ax.id      = grant_idx;
  assign mst_ax.payload = slv_ax.payload;

  // An entry is taken when the address really leaves the path
  assign ax_xfer = slv_ax.valid & slv_ax.ready;

  // Responses pass through and only the ID is replaced
  assign slv_rsp.valid   = mst_rsp.valid;
  assign mst_rsp.ready   = slv_rsp.ready;
  assign slv_rsp.id      = lookup_id;
  assign slv_rsp.payload = mst_rsp.payload;

  assign rsp_xfer = mst_rsp.valid & mst_rsp.ready;

  // Write responses are single beats so each one ends its transaction
  assign rsp_last = LastInPayload ? mst_rsp.payload[0] : 1'b1;

  // Only the final beat of a burst frees the slot
  assign rsp_release = rsp_xfer & rsp_last;

  id_remap_table i_table (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .req_id_i     ( slv_ax.id   ),
    .grant_o      ( grant       ),
    .grant_idx_o  ( grant_idx   ),
    .alloc_i      ( ax_xfer     ),
    .lookup_idx_i ( mst_rsp.id  ),
    .lookup_id_o  ( lookup_id   ),
    .release_i    ( rsp_release )
  );

endmodule

// File: logic/id_remap_pkg.sv
package id_remap_pkg;

  // One table entry for every master port ID
  // The entry index is used directly as the outgoing ID
  localparam int unsigned TableSize = 2 ** axi_bus_pkg::MstIdWidth;

  // Number of transactions that may be outstanding on one entry
  localparam int unsigned MaxTxnsPerId = 3;

  // Outstanding transaction counter of one entry
  // Zero marks the entry as free
  typedef logic [1:0] cnt_t;

  // Index into the remap table
  // Same width as a master port ID so the two convert one to one
  typedef logic [$clog2(TableSize)-1:0] idx_t;

endpackage

// File: logic/id_remap_table.sv
`timescale 1ns/10ps

// Remap table from wide slave port IDs to narrow master port IDs
// Each entry stores one slave ID and how many transactions are open on it
module id_remap_table (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // ID of the address request that asks for an entry
  input  axi_bus_pkg::slv_id_t  req_id_i,
  output logic                  grant_o,
  output id_remap_pkg::idx_t    grant_idx_o,
  // Address transfer took place so the granted entry is taken
  input  logic                  alloc_i,
  // Master ID of the response being returned
  input  id_remap_pkg::idx_t    lookup_idx_i,
  output axi_bus_pkg::slv_id_t  lookup_id_o,
  // Response ended a transaction so the looked up entry gives one back
  input  logic                  release_i
);

  // Stored slave IDs which are only meaningful while the count is nonzero
  axi_bus_pkg::slv_id_t slv_id_q [id_remap_pkg::TableSize];

  // Outstanding transaction count per entry
  id_remap_pkg::cnt_t   cnt_q [id_remap_pkg::TableSize];
  id_remap_pkg::cnt_t   cnt_d [id_remap_pkg::TableSize];

  // Result of the search for an active entry with the requested ID
  logic                 match_found;
  id_remap_pkg::idx_t   match_idx;

  // Result of the search for the lowest free entry
  logic                 free_found;
  id_remap_pkg::idx_t   free_idx;

  // Entry chosen for the current request
  id_remap_pkg::idx_t   grant_idx;

  // Both searches run over the whole table at once
  // The loop walks downward so the lowest index is the last one written
  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    free_found  = 1'b0;
    free_idx    = '0;
    for (int i = int'(id_remap_pkg::TableSize) - 1; i >= 0; i--) begin
      // An active entry holding the same slave ID keeps the ordering of that ID
      if ((cnt_q[i] != '0) && (slv_id_q[i] == req_id_i)) begin
        match_found = 1'b1;
        match_idx   = id_remap_pkg::idx_t'(i);
      end
      if (cnt_q[i] == '0) begin
        free_found = 1'b1;
        free_idx   = id_remap_pkg::idx_t'(i);
      end
    end
  end

  // A matching entry has priority over a free one
  // Active slave IDs are unique in the table so at most one entry can match
  assign grant_idx = match_found ? match_idx : free_idx;

  // A match is only granted below the per ID limit
  // Without a match a free entry is needed
  assign grant_o = match_found ?
                   (cnt_q[match_idx] < id_remap_pkg::cnt_t'(id_remap_pkg::MaxTxnsPerId)) :
                   free_found;

  assign grant_idx_o = grant_idx;

  // Responses restore the slave ID straight from the entry
  assign lookup_id_o = slv_id_q[lookup_idx_i];

  // Next counts apply allocation and release independently
  // When both hit the same entry in one cycle they cancel out
  always_comb begin
    for (int unsigned i = 0; i < id_remap_pkg::TableSize; i++) begin
      cnt_d[i] = cnt_q[i];
      if (alloc_i && (grant_idx == id_remap_pkg::idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] + id_remap_pkg::cnt_t'(1);
      end
      if (release_i && (lookup_idx_i == id_remap_pkg::idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] - id_remap_pkg::cnt_t'(1);
      end
    end
  end

  // All entries are free after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < id_remap_pkg::TableSize; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int unsigned i = 0; i < id_remap_pkg::TableSize; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // The slave ID is written on every allocation
  // On a reuse it is rewritten with the value it already holds
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      slv_id_q[grant_idx] <= req_id_i;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
  -f filelist.f \
  --top-module tb_axi_iw_converter \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation passed"

// File: tb/tb_axi_iw_converter.sv
`timescale 1ns/10ps

// Directed testbench for the AXI4 ID width converter
// A reference model keeps one remap table per direction and predicts every grant and ID
module tb_axi_iw_converter;

  // The tests take about 250 cycles so this leaves a wide margin
  localparam int TimeoutCycles = 4000;

  logic clk_i = 1'b0;
  logic rst_n_i;

  logic slv_aw_valid_i, slv_aw_ready_o, mst_aw_valid_o, mst_aw_ready_i;
  logic slv_ar_valid_i, slv_ar_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic slv_w_valid_i, slv_w_ready_o, slv_w_last_i, mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  logic slv_b_valid_o, slv_b_ready_i, mst_b_valid_i, mst_b_ready_o;
  logic slv_r_valid_o, slv_r_ready_i, slv_r_last_o, mst_r_valid_i, mst_r_ready_o, mst_r_last_i;
  axi_bus_pkg::slv_id_t slv_aw_id_i, slv_b_id_o, slv_ar_id_i, slv_r_id_o;
  axi_bus_pkg::mst_id_t mst_aw_id_o, mst_b_id_i, mst_ar_id_o, mst_r_id_i;
  axi_bus_pkg::addr_t   slv_aw_addr_i, mst_aw_addr_o, slv_ar_addr_i, mst_ar_addr_o;
  axi_bus_pkg::len_t    slv_aw_len_i, mst_aw_len_o, slv_ar_len_i, mst_ar_len_o;
  axi_bus_pkg::data_t   slv_w_data_i, mst_w_data_o, slv_r_data_o, mst_r_data_i;
  axi_bus_pkg::strb_t   slv_w_strb_i, mst_w_strb_o;
  axi_bus_pkg::resp_t   slv_b_resp_o, mst_b_resp_i, slv_r_resp_o, mst_r_resp_i;

  int err_count   = 0;
  int check_count = 0;
  int cycle_count = 0;
  logic [31:0] rng_state = 32'h6051;

  // Reference tables where index 0 is the write side and index 1 the read side
  axi_bus_pkg::slv_id_t model_id  [2][4];
  int                   model_cnt [2][4];

  // Master IDs with a transaction still open, used by the random traffic
  axi_bus_pkg::mst_id_t wq [$];
  axi_bus_pkg::mst_id_t rq [$];

  axi_iw_converter axi_iw_converter_i (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_count);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Returns the entry that a request may use, or -1 when it has to wait
  function automatic int model_grant(input bit rd, input axi_bus_pkg::slv_id_t id);
    int free_idx;
    free_idx = -1;
    // An open entry with the same ID must be reused, and only below the limit
    for (int i = 0; i < 4; i++) begin
      if ((model_cnt[rd][i] > 0) && (model_id[rd][i] == id)) begin
        return (model_cnt[rd][i] < int'(id_remap_pkg::MaxTxnsPerId)) ? i : -1;
      end
    end
    // Otherwise the lowest entry with nothing open
    for (int i = 3; i >= 0; i--) begin
      if (model_cnt[rd][i] == 0) begin
        free_idx = i;
      end
    end
    return free_idx;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
    end
  endtask

  // Offers one address for a cycle and checks the master side against the model
  // It is entered and left just after a falling edge and valid stays up if nothing moved
  // The returned xfer is the slave side ready that the DUT showed
  task automatic send_addr(input bit rd, input axi_bus_pkg::slv_id_t id,
                           input axi_bus_pkg::addr_t addr, input axi_bus_pkg::len_t len,
                           input bit rdy, output bit xfer, output axi_bus_pkg::mst_id_t mid);
    int exp_idx;
    bit exp_xfer;
    logic v;
    logic r;
    axi_bus_pkg::addr_t a;
    axi_bus_pkg::len_t l;
    if (rd) begin
      slv_ar_valid_i = 1'b1;
      slv_ar_id_i    = id;
      slv_ar_addr_i  = addr;
      slv_ar_len_i   = len;
      mst_ar_ready_i = rdy;
    end else begin
      slv_aw_valid_i = 1'b1;
      slv_aw_id_i    = id;
      slv_aw_addr_i  = addr;
      slv_aw_len_i   = len;
      mst_aw_ready_i = rdy;
    end
    #5;
    exp_idx = model_grant(rd, id);
    v   = rd ? mst_ar_valid_o : mst_aw_valid_o;
    r   = rd ? slv_ar_ready_o : slv_aw_ready_o;
    mid = rd ? mst_ar_id_o : mst_aw_id_o;
    a   = rd ? mst_ar_addr_o : mst_aw_addr_o;
    l   = rd ? mst_ar_len_o : mst_aw_len_o;
    compare_value(rd ? "mst_ar_valid_o" : "mst_aw_valid_o", 64'(exp_idx >= 0), 64'(v));
    compare_value(rd ? "slv_ar_ready_o" : "slv_aw_ready_o", 64'((exp_idx >= 0) && rdy), 64'(r));
    if (exp_idx >= 0) begin
      compare_value(rd ? "mst_ar_id_o" : "mst_aw_id_o", 64'(exp_idx), 64'(mid));
      compare_value(rd ? "mst_ar_addr_o" : "mst_aw_addr_o", 64'(addr), 64'(a));
      compare_value(rd ? "mst_ar_len_o" : "mst_aw_len_o", 64'(len), 64'(l));
    end
    exp_xfer = (exp_idx >= 0) && rdy;
    xfer     = r;
    @(posedge clk_i);
    if (exp_xfer) begin
      model_id[rd][exp_idx] = id;
      model_cnt[rd][exp_idx]++;
    end
    @(negedge clk_i);
    if (xfer && rd) begin
      slv_ar_valid_i = 1'b0;
    end else if (xfer) begin
      slv_aw_valid_i = 1'b0;
    end
  endtask

  // Returns one B or R beat and checks that the original ID comes back
  task automatic send_resp(input bit rd, input axi_bus_pkg::mst_id_t mid,
                           input axi_bus_pkg::data_t data, input axi_bus_pkg::resp_t resp,
                           input bit last, output axi_bus_pkg::slv_id_t sid);
    if (model_cnt[rd][mid] == 0) begin
      err_count++;
      $display("Response sent at %0t on master ID %0d, which has nothing open", $time, mid);
    end
    if (rd) begin
      mst_r_valid_i = 1'b1;
      mst_r_id_i    = mid;
      mst_r_data_i  = data;
      mst_r_resp_i  = resp;
      mst_r_last_i  = last;
      slv_r_ready_i = 1'b1;
      #5;
      sid = slv_r_id_o;
      compare_value("slv_r_valid_o", 64'(1), 64'(slv_r_valid_o));
      compare_value("mst_r_ready_o", 64'(1), 64'(mst_r_ready_o));
      compare_value("slv_r_id_o", 64'(model_id[1][mid]), 64'(sid));
      compare_value("slv_r_data_o", 64'(data), 64'(slv_r_data_o));
      compare_value("slv_r_resp_o", 64'(resp), 64'(slv_r_resp_o));
      compare_value("slv_r_last_o", 64'(last), 64'(slv_r_last_o));
    end else begin
      mst_b_valid_i = 1'b1;
      mst_b_id_i    = mid;
      mst_b_resp_i  = resp;
      slv_b_ready_i = 1'b1;
      #5;
      sid = slv_b_id_o;
      compare_value("slv_b_valid_o", 64'(1), 64'(slv_b_valid_o));
      compare_value("mst_b_ready_o", 64'(1), 64'(mst_b_ready_o));
      compare_value("slv_b_id_o", 64'(model_id[0][mid]), 64'(sid));
      compare_value("slv_b_resp_o", 64'(resp), 64'(slv_b_resp_o));
    end
    @(posedge clk_i);
    // Every B ends a write while an R only ends a read on its last beat
    if ((!rd || last) && (model_cnt[rd][mid] > 0)) begin
      model_cnt[rd][mid]--;
    end
    @(negedge clk_i);
    mst_r_valid_i = 1'b0;
    mst_b_valid_i = 1'b0;
  endtask

  task automatic send_w_beat(input axi_bus_pkg::data_t data, input axi_bus_pkg::strb_t strb,
                             input bit last);
    slv_w_valid_i = 1'b1;
    slv_w_data_i  = data;
    slv_w_strb_i  = strb;
    slv_w_last_i  = last;
    mst_w_ready_i = 1'b1;
    #5;
    compare_value("mst_w_valid_o", 64'(1), 64'(mst_w_valid_o));
    compare_value("slv_w_ready_o", 64'(1), 64'(slv_w_ready_o));
    compare_value("mst_w_data_o", 64'(data), 64'(mst_w_data_o));
    compare_value("mst_w_strb_o", 64'(strb), 64'(mst_w_strb_o));
    compare_value("mst_w_last_o", 64'(last), 64'(mst_w_last_o));
    @(negedge clk_i);
    slv_w_valid_i = 1'b0;
  endtask

  task automatic single_write();
    bit x;
    axi_bus_pkg::mst_id_t m;
    axi_bus_pkg::slv_id_t s;
    send_addr(1'b0, 4'd9, 32'h1000_0040, 8'd1, 1'b1, x, m);
    compare_value("mst_aw_id_o", 64'(0), 64'(m));
    send_w_beat(32'hdead_beef, 4'hf, 1'b0);
    send_w_beat(32'h0123_4567, 4'h3, 1'b1);
    send_resp(1'b0, 2'd0, '0, 2'b10, 1'b1, s);
    compare_value("slv_b_id_o", 64'(9), 64'(s));
    // Entry 0 is free again so a different ID lands on it
    send_addr(1'b0, 4'd3, 32'h2000_0000, 8'd0, 1'b1, x, m);
    compare_value("mst_aw_id_o", 64'(0), 64'(m));
    send_resp(1'b0, 2'd0, '0, 2'b00, 1'b1, s);
  endtask

  task automatic reuse_and_alloc();
    bit x;
    axi_bus_pkg::mst_id_t m;
    axi_bus_pkg::slv_id_t s;
    send_addr(1'b1, 4'd5, 32'h0000_0100, 8'd0, 1'b1, x, m);
    compare_value("mst_ar_id_o", 64'(0), 64'(m));
    send_addr(1'b1, 4'd5, 32'h0000_0200, 8'd0, 1'b1, x, m);
    compare_value("mst_ar_id_o", 64'(0), 64'(m));
    send_addr(1'b1, 4'd12, 32'h0000_0300, 8'd0, 1'b1, x, m);
    compare_value("mst_ar_id_o", 64'(1), 64'(m));
    send_resp(1'b1, 2'd0, 32'h11, 2'b00, 1'b1, s);
    compare_value("slv_r_id_o", 64'(5), 64'(s));
    send_resp(1'b1, 2'd0, 32'h22, 2'b00, 1'b1, s);
    compare_value("slv_r_id_o", 64'(5), 64'(s));
    send_resp(1'b1, 2'd1, 32'h33, 2'b01, 1'b1, s);
    compare_value("slv_r_id_o", 64'(12), 64'(s));
  endtask

  task automatic full_table_and_limit();
    bit x;
    axi_bus_pkg::mst_id_t m;
    axi_bus_pkg::slv_id_t s;
    for (int i = 0; i < 4; i++) begin
      send_addr(1'b1, axi_bus_pkg::slv_id_t'(i + 1), 32'h400, 8'd0, 1'b1, x, m);
      compare_value("mst_ar_id_o", 64'(i), 64'(m));
    end
    // A fifth ID has nowhere to go and is held until entry 2 frees up
    send_addr(1'b1, 4'd6, 32'h500, 8'd0, 1'b1, x, m);
    compare_value("slv_ar_ready_o", 64'(0), 64'(x));
    send_resp(1'b1, 2'd2, 32'h44, 2'b00, 1'b1, s);
    compare_value("slv_r_id_o", 64'(3), 64'(s));
    send_addr(1'b1, 4'd6, 32'h500, 8'd0, 1'b1, x, m);
    compare_value("mst_ar_id_o", 64'(2), 64'(m));
    for (int i = 0; i < 4; i++) begin
      send_resp(1'b1, axi_bus_pkg::mst_id_t'(i), 32'h0, 2'b00, 1'b1, s);
    end
    // Three reads on one ID fill the entry and a fourth one waits
    for (int i = 0; i < 3; i++) begin
      send_addr(1'b1, 4'd7, 32'h600, 8'd0, 1'b1, x, m);
      compare_value("mst_ar_id_o", 64'(0), 64'(m));
    end
    send_addr(1'b1, 4'd7, 32'h700, 8'd0, 1'b1, x, m);
    compare_value("slv_ar_ready_o", 64'(0), 64'(x));
    send_resp(1'b1, 2'd0, 32'h55, 2'b00, 1'b1, s);
    send_addr(1'b1, 4'd7, 32'h700, 8'd0, 1'b1, x, m);
    compare_value("slv_ar_ready_o", 64'(1), 64'(x));
    repeat (3) send_resp(1'b1, 2'd0, 32'h0, 2'b00, 1'b1, s);
  endtask

  task automatic read_bursts();
    bit x;
    axi_bus_pkg::mst_id_t m;
    axi_bus_pkg::slv_id_t s;
    send_addr(1'b1, 4'd8, 32'h800, 8'd3, 1'b1, x, m);
    for (int i = 0; i < 3; i++) begin
      send_resp(1'b1, 2'd0, 32'(i), 2'b00, 1'b0, s);
      compare_value("slv_r_id_o", 64'(8), 64'(s));
    end
    // Entry 0 is still held mid burst so the next ID goes to entry 1
    send_addr(1'b1, 4'd10, 32'h900, 8'd0, 1'b1, x, m);
    compare_value("mst_ar_id_o", 64'(1), 64'(m));
    send_resp(1'b1, 2'd0, 32'h3, 2'b00, 1'b1, s);
    send_addr(1'b1, 4'd11, 32'ha00, 8'd0, 1'b1, x, m);
    compare_value("mst_ar_id_o", 64'(0), 64'(m));
    send_resp(1'b1, 2'd0, 32'h0, 2'b00, 1'b1, s);
    send_resp(1'b1, 2'd1, 32'h0, 2'b00, 1'b1, s);
  endtask

  task automatic ar_backpressure();
    bit x;
    axi_bus_pkg::mst_id_t m;
    axi_bus_pkg::slv_id_t s;
    repeat (2) begin
      send_addr(1'b1, 4'd13, 32'hb00, 8'd0, 1'b0, x, m);
      compare_value("slv_ar_ready_o", 64'(0), 64'(x));
    end
    send_addr(1'b1, 4'd13, 32'hb00, 8'd0, 1'b1, x, m);
    compare_value("mst_ar_id_o", 64'(0), 64'(m));
    send_resp(1'b1, 2'd0, 32'h0, 2'b00, 1'b1, s);
    // Entry 0 is only free again if the stalled cycles counted nothing
    send_addr(1'b1, 4'd14, 32'hc00, 8'd0, 1'b1, x, m);
    compare_value("mst_ar_id_o", 64'(0), 64'(m));
    send_resp(1'b1, 2'd0, 32'h0, 2'b00, 1'b1, s);
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    bit rd;
    bit x;
    int k;
    int e;
    axi_bus_pkg::mst_id_t m;
    axi_bus_pkg::slv_id_t s;
    for (int n = 0; n < 200; n++) begin
      r  = next_random();
      rd = r[0];
      e  = model_grant(rd, r[7:4]);
      // Issue when asked to or when that side has nothing to answer
      if ((r[1] || (rd ? rq.size() == 0 : wq.size() == 0)) && (e >= 0)) begin
        send_addr(rd, r[7:4], next_random(), r[15:8], 1'b1, x, m);
        if (rd) rq.push_back(axi_bus_pkg::mst_id_t'(e));
        else wq.push_back(axi_bus_pkg::mst_id_t'(e));
      end else if (rd) begin
        k = int'(next_random() % 32'(rq.size()));
        send_resp(1'b1, rq[k], next_random(), r[9:8], r[3:2] != 2'b00, s);
        if (r[3:2] != 2'b00) rq.delete(k);
      end else begin
        k = int'(next_random() % 32'(wq.size()));
        send_resp(1'b0, wq[k], '0, r[9:8], 1'b1, s);
        wq.delete(k);
      end
    end
  endtask

  initial begin
    for (int d = 0; d < 2; d++) begin
      for (int i = 0; i < 4; i++) begin
        model_id[d][i]  = '0;
        model_cnt[d][i] = 0;
      end
    end
    rst_n_i        = 1'b0;
    slv_aw_valid_i = 1'b0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_w_valid_i  = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = 1'b0;
    slv_b_ready_i  = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    single_write();
    reuse_and_alloc();
    full_table_and_limit();
    read_bursts();
    ar_backpressure();
    random_traffic();
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
